/* src/obi_sl_pkg.sv */
// ----------------------------------------
// sizes and types for a single observed OBI bus
// depth must stay a power of two for pointer wrap
// ----------------------------------------
`default_nettype none

package obi_sl_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // most accepted requests that may wait for a response
  localparam int MAX_OUTSTANDING = 4;

  // outstanding count must reach MAX_OUTSTANDING
  localparam int CNT_W = 3;

  // read/write pointer width of the attribute store
  localparam int PTR_W = $clog2(MAX_OUTSTANDING);

  // count value that marks the tracker as full
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MAX_OUTSTANDING);

  // ----------------------------------------
  // types
  // ----------------------------------------

  // address phase state
  // stall means req seen without gnt last cycle
  typedef enum logic {
    ADDR_IDLE  = 1'b0,
    ADDR_STALL = 1'b1
  } addr_state_e;

  // attributes that follow a request to its response
  typedef struct packed {
    // request was a write
    logic store;
    // request carried integrity
    logic integrity;
    // grant parity mismatch seen during the address phase
    logic gntpar_err;
  } req_attr_t;

endpackage

`default_nettype wire

/* src/obi_obs_if.sv */
// ----------------------------------------
// per-cycle bus events, all combinational
// no clock here, stages sample with their own
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface obi_obs_if;

  // ----------------------------------------
  // observed events
  // ----------------------------------------

  // req and gnt high together, address phase done
  logic addr_accept;
  // response phase this cycle
  logic resp_valid;
  // req high, address phase in progress
  logic req_active;
  // attributes of the request on the bus this cycle
  obi_sl_pkg::req_attr_t attr;

  // ----------------------------------------
  // modports
  // ----------------------------------------

  // producing stage
  modport src_mp (
    output addr_accept,
    output resp_valid,
    output req_active,
    output attr
  );

  // consuming stage
  modport dst_mp (
    input addr_accept,
    input resp_valid,
    input req_active,
    input attr
  );

endinterface

`default_nettype wire

/* src/obi_phase_monitor.sv */
// ----------------------------------------
// count clamps at 0 and at MAX_OUTSTANDING
// protocol errors are flagged downstream
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module obi_phase_monitor (
  input  logic                         in_support_if,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  logic                         gnt_i,
  input  logic                         rvalid_i,
  input  logic                         req_store_i,
  input  logic                         req_integrity_i,
  output logic                         addr_ph_cont_o,
  output logic                         resp_ph_cont_o,
  output logic [obi_sl_pkg::CNT_W-1:0] v_addr_ph_cnt_o,
  obi_obs_if.src_mp                    obs_o
);

  // ----------------------------------------
  // local signals
  // ----------------------------------------

  obi_sl_pkg::addr_state_e addr_state_q;
  obi_sl_pkg::addr_state_e addr_state_d;
  logic [obi_sl_pkg::CNT_W-1:0] cnt_q;
  logic accept;
  logic cnt_inc;
  logic cnt_dec;

  // ----------------------------------------
  // address phase state
  // ----------------------------------------

  assign accept = req_i && gnt_i;

  // a stall is req without gnt
  // anything else ends or skips the stall
  always_comb begin
    if (req_i && !gnt_i) begin
      addr_state_d = obi_sl_pkg::ADDR_STALL;
    end else begin
      addr_state_d = obi_sl_pkg::ADDR_IDLE;
    end
  end

  // ----------------------------------------
  // outstanding counter
  // ----------------------------------------

  // a full tracker still takes an accept when a response leaves
  assign cnt_inc = accept && ((cnt_q != obi_sl_pkg::CNT_FULL) || rvalid_i);
  // response on empty tracker does not wrap the count
  assign cnt_dec = rvalid_i && (cnt_q != '0);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      addr_state_q <= obi_sl_pkg::ADDR_IDLE;
      cnt_q        <= '0;
    end else begin
      addr_state_q <= addr_state_d;
      // accept and response together leave the count as is
      if (cnt_inc && !cnt_dec) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_dec && !cnt_inc) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  // req held over from a stalled cycle
  assign addr_ph_cont_o  = req_i && (addr_state_q == obi_sl_pkg::ADDR_STALL);
  // waiting on at least one response
  assign resp_ph_cont_o  = (cnt_q != '0) && !rvalid_i;
  assign v_addr_ph_cnt_o = cnt_q;

  // observation for the next stage
  // parity error is filled in by the checker
  always_comb begin
    obs_o.addr_accept     = accept;
    obs_o.resp_valid      = rvalid_i;
    obs_o.req_active      = req_i;
    obs_o.attr.store      = req_store_i;
    obs_o.attr.integrity  = req_integrity_i;
    obs_o.attr.gntpar_err = 1'b0;
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // a stalled request may not be withdrawn before its grant
  a_stall_holds_req: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    (addr_state_q == obi_sl_pkg::ADDR_STALL) |-> req_i
  ) else $error("request dropped during a stalled address phase");

endmodule

`default_nettype wire

/* src/gntpar_checker.sv */
// ----------------------------------------
// gntpar must be the inverse of gnt while req is high
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gntpar_checker (
  input  logic      in_support_if,
  input  logic      rst_n_i,
  input  logic      gntpar_i,
  input  logic      gnt_i,
  obi_obs_if.dst_mp obs_i,
  obi_obs_if.src_mp obs_o
);

  // ----------------------------------------
  // parity error
  // ----------------------------------------

  // error seen earlier in the same stalled phase
  logic sticky_err_q;
  logic gntpar_err;

  // equal gnt and gntpar is a parity violation
  // an old error in this phase keeps counting
  assign gntpar_err = obs_i.req_active && ((gnt_i == gntpar_i) || sticky_err_q);

  // keep the error only while the phase is stalled
  // granted or dropped request starts clean
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      sticky_err_q <= 1'b0;
    end else if (obs_i.req_active && !gnt_i) begin
      sticky_err_q <= gntpar_err;
    end else begin
      sticky_err_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // forwarding
  // ----------------------------------------

  // pass everything through, only the error bit changes
  always_comb begin
    obs_o.addr_accept     = obs_i.addr_accept;
    obs_o.resp_valid      = obs_i.resp_valid;
    obs_o.req_active      = obs_i.req_active;
    obs_o.attr            = obs_i.attr;
    obs_o.attr.gntpar_err = gntpar_err;
  end

endmodule

`default_nettype wire

/* src/req_attribute_fifo.sv */
// ----------------------------------------
// in-order responses only, response at least one cycle after its grant
// violations raise protocol_err_o until reset
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module req_attribute_fifo (
  input  logic      in_support_if,
  input  logic      rst_n_i,
  obi_obs_if.dst_mp obs_i,
  output logic      req_was_store_o,
  output logic      req_had_integrity_o,
  output logic      gntpar_error_in_resp_o,
  output logic      protocol_err_o
);

  // ----------------------------------------
  // storage and pointers
  // ----------------------------------------

  obi_sl_pkg::req_attr_t mem [obi_sl_pkg::MAX_OUTSTANDING];

  logic [obi_sl_pkg::PTR_W-1:0] wr_ptr_q;
  logic [obi_sl_pkg::PTR_W-1:0] rd_ptr_q;
  logic [obi_sl_pkg::CNT_W-1:0] count_q;
  logic full;
  logic empty;
  logic push;
  logic pop;
  logic push_err;
  logic pop_err;
  logic protocol_err_q;
  obi_sl_pkg::req_attr_t head;

  assign empty = (count_q == '0);
  assign full  = (count_q == obi_sl_pkg::CNT_FULL);

  // full store still takes a push when the head leaves
  assign push = obs_i.addr_accept && (!full || obs_i.resp_valid);
  assign pop  = obs_i.resp_valid && !empty;

  // ----------------------------------------
  // protocol errors
  // ----------------------------------------

  // accept with no room left
  assign push_err = obs_i.addr_accept && full && !obs_i.resp_valid;
  // response with nothing outstanding
  assign pop_err  = obs_i.resp_valid && empty;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      protocol_err_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // sticky until reset
      if (push_err || pop_err) begin
        protocol_err_q <= 1'b1;
      end
    end
  end

  // attribute payload, written at the tail
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q] <= obs_i.attr;
    end
  end

  // ----------------------------------------
  // response outputs
  // ----------------------------------------

  assign head = mem[rd_ptr_q];

  // head entry only while a valid response is on the bus
  always_comb begin
    if (pop) begin
      req_was_store_o        = head.store;
      req_had_integrity_o    = head.integrity;
      gntpar_error_in_resp_o = head.gntpar_err;
    end else begin
      req_was_store_o        = 1'b0;
      req_had_integrity_o    = 1'b0;
      gntpar_error_in_resp_o = 1'b0;
    end
  end

  assign protocol_err_o = protocol_err_q;

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // these fire on bus misuse, also reported on protocol_err_o
  a_no_push_full: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    (full && !obs_i.resp_valid) |-> !obs_i.addr_accept
  ) else $warning("accept while the request tracker is full");

  a_no_pop_empty: assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    empty |-> !obs_i.resp_valid
  ) else $warning("response with no outstanding request");

endmodule

`default_nettype wire

/* src/obi_support_logic.sv */
// ----------------------------------------
// passive observer of one OBI bus, drives nothing back
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module obi_support_logic (
  input  logic                         in_support_if,
  input  logic                         rst_n_i,
  input  logic                         req_i,
  input  logic                         gnt_i,
  input  logic                         gntpar_i,
  input  logic                         rvalid_i,
  input  logic                         req_store_i,
  input  logic                         req_integrity_i,
  output logic                         addr_ph_cont_o,
  output logic                         resp_ph_cont_o,
  output logic [obi_sl_pkg::CNT_W-1:0] v_addr_ph_cnt_o,
  output logic                         req_was_store_o,
  output logic                         req_had_integrity_o,
  output logic                         gntpar_error_in_resp_o,
  output logic                         protocol_err_o
);

  // ----------------------------------------
  // stage links
  // ----------------------------------------

  // monitor to parity checker
  obi_obs_if obs_a ();
  // parity checker to attribute store
  obi_obs_if obs_b ();

  // ----------------------------------------
  // stages
  // ----------------------------------------

  // stage 1, phase tracking and outstanding count
  obi_phase_monitor u_phase_monitor (
    .in_support_if   (in_support_if),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .gnt_i           (gnt_i),
    .rvalid_i        (rvalid_i),
    .req_store_i     (req_store_i),
    .req_integrity_i (req_integrity_i),
    .addr_ph_cont_o  (addr_ph_cont_o),
    .resp_ph_cont_o  (resp_ph_cont_o),
    .v_addr_ph_cnt_o (v_addr_ph_cnt_o),
    .obs_o           (obs_a.src_mp)
  );

  // stage 2, grant parity
  // raw gnt needed for the parity compare
  gntpar_checker u_gntpar_checker (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .gntpar_i      (gntpar_i),
    .gnt_i         (gnt_i),
    .obs_i         (obs_a.dst_mp),
    .obs_o         (obs_b.src_mp)
  );

  // stage 3, attributes back with each response
  req_attribute_fifo u_req_attribute_fifo (
    .in_support_if          (in_support_if),
    .rst_n_i                (rst_n_i),
    .obs_i                  (obs_b.dst_mp),
    .req_was_store_o        (req_was_store_o),
    .req_had_integrity_o    (req_had_integrity_o),
    .gntpar_error_in_resp_o (gntpar_error_in_resp_o),
    .protocol_err_o         (protocol_err_o)
  );

endmodule

`default_nettype wire

/* bench/obi_support_logic_tb.sv */
// ----------------------------------------
// vectors read from bench/obi_sl_vectors.txt, run from the project root
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module obi_support_logic_tb;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------

  logic clk;
  logic rst_n;
  logic req;
  logic gnt;
  logic gntpar;
  logic rvalid;
  logic req_store;
  logic req_integrity;
  logic addr_ph_cont;
  logic resp_ph_cont;
  logic [obi_sl_pkg::CNT_W-1:0] v_addr_ph_cnt;
  logic req_was_store;
  logic req_had_integrity;
  logic gntpar_error_in_resp;
  logic protocol_err;

  // vector file handle and bookkeeping
  int fd;
  int line_no;
  int checks;
  int errors;

  // inputs of the current vector line
  int v_req;
  int v_gnt;
  int v_gntpar;
  int v_rvalid;
  int v_store;
  int v_integrity;

  // expected outputs of the current vector line
  int e_addr_cont;
  int e_resp_cont;
  int e_cnt;
  int e_was_store;
  int e_had_integrity;
  int e_gntpar_err;
  int e_protocol_err;

  obi_support_logic dut (
    .in_support_if          (clk),
    .rst_n_i                (rst_n),
    .req_i                  (req),
    .gnt_i                  (gnt),
    .gntpar_i               (gntpar),
    .rvalid_i               (rvalid),
    .req_store_i            (req_store),
    .req_integrity_i        (req_integrity),
    .addr_ph_cont_o         (addr_ph_cont),
    .resp_ph_cont_o         (resp_ph_cont),
    .v_addr_ph_cnt_o        (v_addr_ph_cnt),
    .req_was_store_o        (req_was_store),
    .req_had_integrity_o    (req_had_integrity),
    .gntpar_error_in_resp_o (gntpar_error_in_resp),
    .protocol_err_o         (protocol_err)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      $display("FAILED at %0t ns, vector line %0d: %s expected %0d got %0d",
               $time, line_no, name, expected, actual);
      errors++;
    end
  endtask

  // all seven outputs against the current line
  task automatic compare_outputs();
    check_value("addr_ph_cont_o", e_addr_cont, int'(addr_ph_cont));
    check_value("resp_ph_cont_o", e_resp_cont, int'(resp_ph_cont));
    check_value("v_addr_ph_cnt_o", e_cnt, int'(v_addr_ph_cnt));
    check_value("req_was_store_o", e_was_store, int'(req_was_store));
    check_value("req_had_integrity_o", e_had_integrity, int'(req_had_integrity));
    check_value("gntpar_error_in_resp_o", e_gntpar_err, int'(gntpar_error_in_resp));
    check_value("protocol_err_o", e_protocol_err, int'(protocol_err));
  endtask

  // one vector per falling edge, outputs sampled 10 ns later
  task automatic run_vectors();
    string line;
    int rc;
    int loops;
    logic done;
    loops = 0;
    done  = 1'b0;
    while (!done) begin
      if ($feof(fd) != 0) begin
        done = 1'b1;
      end else begin
        rc = $fgets(line, fd);
        line_no++;
        // skip blank and comment lines
        if (rc != 0 && line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                       v_req, v_gnt, v_gntpar, v_rvalid, v_store, v_integrity,
                       e_addr_cont, e_resp_cont, e_cnt, e_was_store,
                       e_had_integrity, e_gntpar_err, e_protocol_err);
          if (rc != 13) begin
            $display("error: vector line %0d has %0d fields where 13 are needed",
                     line_no, rc);
            errors++;
          end else begin
            @(negedge clk);
            req           = (v_req != 0);
            gnt           = (v_gnt != 0);
            gntpar        = (v_gntpar != 0);
            rvalid        = (v_rvalid != 0);
            req_store     = (v_store != 0);
            req_integrity = (v_integrity != 0);
            #10;
            compare_outputs();
          end
        end
      end
      loops++;
      if (!done && loops >= 1000) begin
        $display("error: vector loop passed 1000 cycles before the end of the file");
        errors++;
        done = 1'b1;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = 1'b0;
    gnt           = 1'b0;
    gntpar        = 1'b1;
    rvalid        = 1'b0;
    req_store     = 1'b0;
    req_integrity = 1'b0;
    line_no       = 0;
    checks        = 0;
    errors        = 0;
    fd = $fopen("bench/obi_sl_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: could not open bench/obi_sl_vectors.txt for reading");
      errors++;
    end
    // reset over 4 rising edges, released between edges
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (fd != 0) begin
      run_vectors();
      $fclose(fd);
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/obi_sl_vectors.txt */
# inputs:  req gnt gntpar rvalid store integrity
# outputs: addr_ph_cont resp_ph_cont cnt was_store had_integrity gntpar_err protocol_err
# idle bus after reset
0 0 1 0 0 0   0 0 0 0 0 0 0
0 0 1 0 0 0   0 0 0 0 0 0 0
# store request stalled three cycles, then granted
1 0 1 0 1 0   0 0 0 0 0 0 0
1 0 1 0 1 0   1 0 0 0 0 0 0
1 0 1 0 1 0   1 0 0 0 0 0 0
1 1 0 0 1 0   1 0 0 0 0 0 0
0 0 1 0 0 0   0 1 1 0 0 0 0
0 0 1 1 0 0   0 0 1 1 0 0 0
0 0 1 0 0 0   0 0 0 0 0 0 0
# three back-to-back accepts with mixed attributes
1 1 0 0 0 1   0 0 0 0 0 0 0
1 1 0 0 1 1   0 1 1 0 0 0 0
1 1 0 0 0 0   0 1 2 0 0 0 0
0 0 1 0 0 0   0 1 3 0 0 0 0
0 0 1 1 0 0   0 0 3 0 1 0 0
0 0 1 0 0 0   0 1 2 0 0 0 0
# accept and response in one cycle
1 1 0 1 1 0   0 0 2 1 1 0 0
0 0 1 0 0 0   0 1 2 0 0 0 0
0 0 1 1 0 0   0 0 2 0 0 0 0
0 0 1 0 0 0   0 1 1 0 0 0 0
0 0 1 1 0 0   0 0 1 1 0 0 0
0 0 1 0 0 0   0 0 0 0 0 0 0
# parity error early in a stall, then correct parity
1 0 0 0 0 1   0 0 0 0 0 0 0
1 0 1 0 0 1   1 0 0 0 0 0 0
1 1 0 0 0 1   1 0 0 0 0 0 0
# clean following request
1 1 0 0 1 1   0 1 1 0 0 0 0
0 0 1 0 0 0   0 1 2 0 0 0 0
0 0 1 1 0 0   0 0 2 0 1 1 0
0 0 1 1 0 0   0 0 1 1 1 0 0
0 0 1 0 0 0   0 0 0 0 0 0 0
# response with nothing outstanding
0 0 1 1 0 0   0 0 0 0 0 0 0
0 0 1 0 0 0   0 0 0 0 0 0 1
0 0 1 0 0 0   0 0 0 0 0 0 1
# error stays through a normal transfer
1 1 0 0 1 0   0 0 0 0 0 0 1
0 0 1 1 0 0   0 0 1 1 0 0 1
0 0 1 0 0 0   0 0 0 0 0 0 1

/* src.f */
src/obi_sl_pkg.sv
src/obi_obs_if.sv
src/obi_phase_monitor.sv
src/gntpar_checker.sv
src/req_attribute_fifo.sv
src/obi_support_logic.sv
bench/obi_support_logic_tb.sv

/* Makefile */
# Verilator build and run of the OBI support logic testbench

TOP := obi_support_logic_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
